/* rtl/lsu_config.svh */
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

`define LSU_XLEN    32 // data word width.
`define LSU_ADDR_W  32 // bus address width.
`define LSU_SHAMT_W 5  // shift amount width, counter field is one bit wider.

`endif

/* rtl/serial_op_pkg.sv */
`default_nettype none

`include "lsu_config.svh"

package serial_op_pkg;

   typedef enum logic [1:0] {
      LOAD  = 2'd0, // read one word, extract bytes.
      STORE = 2'd1, // align and write one word.
      SLL   = 2'd2, // logical shift left.
      SRL   = 2'd3  // logical shift right.
   } lsu_op_e;

   typedef enum logic [1:0] {
      BYTE = 2'd0,
      HALF = 2'd1,
      WORD = 2'd2
   } mem_size_e;

   typedef enum logic [2:0] {
      IDLE = 3'd0, // waiting for a command.
      INIT = 3'd1, // operand shifted into the buffer.
      BUS  = 3'd2, // bus request outstanding.
      EXEC = 3'd3, // load extraction or shift counting.
      RESP = 3'd4  // response held until taken.
   } seq_phase_e;

   typedef struct packed {
      logic [`LSU_XLEN-`LSU_SHAMT_W-2:0] upper; // data bits above the counter.
      logic [`LSU_SHAMT_W:0]             cnt;   // shift count plus wrap bit.
   } bufreg_fields_t;

   // the same buffer word is read as data or as a down-counter
   typedef union packed {
      logic [`LSU_XLEN-1:0] word;
      bufreg_fields_t       f;
   } bufreg_word_u;

endpackage

`default_nettype wire

/* rtl/mem_bus_pkg.sv */
`default_nettype none

`include "lsu_config.svh"

package mem_bus_pkg;

   localparam int unsigned BE_W = `LSU_XLEN / 8; // one enable per byte lane.

   typedef logic [`LSU_ADDR_W-1:0] mem_addr_t;
   typedef logic [`LSU_XLEN-1:0]   mem_word_t;
   typedef logic [BE_W-1:0]        mem_be_t;

endpackage

`default_nettype wire

/* rtl/serial_sequencer.sv */
`default_nettype none

module serial_sequencer (
   input  wire                         i_clk,
   input  wire                         i_rst_n,
   input  wire                         i_cmd_valid,
   input  wire serial_op_pkg::lsu_op_e i_cmd_op,
   input  wire [1:0]                   i_cmd_lsb,
   input  wire                         i_mem_done,
   input  wire                         i_sh_done,
   input  wire                         i_rsp_ready,
   output logic                        o_cmd_ready,
   output serial_op_pkg::seq_phase_e   o_phase,
   output logic                        o_en,
   output logic                        o_init,
   output logic                        o_cnt_done,
   output logic [1:0]                  o_bytecnt,
   output logic [1:0]                  o_lsb,
   output logic                        o_shift_op,
   output logic                        o_shift_left
);
   import serial_op_pkg::*;

   seq_phase_e phase_q;
   lsu_op_e    op_q;
   logic [1:0] lsb_q;
   logic [4:0] bit_cnt;
   logic       accept;
   logic       is_shift;
   logic       in_exec;

   assign o_cmd_ready = (phase_q == IDLE);         // one command in flight.
   assign accept      = i_cmd_valid & o_cmd_ready;
   assign is_shift    = (op_q == SLL) | (op_q == SRL);
   assign in_exec     = (phase_q == EXEC);

   assign o_phase      = phase_q;
   assign o_init       = (phase_q == INIT);
   assign o_en         = o_init | (in_exec & !is_shift); // shift exec runs on the counter.
   assign o_cnt_done   = o_en & (bit_cnt == 5'd31);
   assign o_bytecnt    = bit_cnt[4:3];                   // byte index within the word.
   assign o_lsb        = lsb_q;
   assign o_shift_op   = is_shift & (o_init | in_exec);  // buffer idle outside these.
   assign o_shift_left = (op_q == SLL);

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         phase_q <= IDLE;
         op_q    <= LOAD;
         lsb_q   <= 2'd0;
         bit_cnt <= 5'd0;
      end else begin
         if (o_en)
            bit_cnt <= bit_cnt + 5'd1; // wraps back to zero after bit 31.
         case (phase_q)
            IDLE: begin
               if (accept) begin
                  op_q    <= i_cmd_op;
                  lsb_q   <= i_cmd_lsb;
                  phase_q <= (i_cmd_op == LOAD) ? BUS : INIT; // loads go to the bus first.
               end
            end
            INIT: begin
               if (o_cnt_done)
                  phase_q <= is_shift ? EXEC : BUS;
            end
            BUS: begin
               if (i_mem_done)
                  phase_q <= (op_q == LOAD) ? EXEC : RESP;
            end
            EXEC: begin
               if (is_shift ? i_sh_done : o_cnt_done)
                  phase_q <= RESP;
            end
            RESP: begin
               if (i_rsp_ready)
                  phase_q <= IDLE;
            end
            default: phase_q <= IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

/* rtl/operand_serializer.sv */
`default_nettype none

`include "lsu_config.svh"

module operand_serializer (
   input  wire                         i_clk,
   input  wire                         i_capture,
   input  wire                         i_en,
   input  wire                         i_shift_op,
   input  wire mem_bus_pkg::mem_word_t i_rs2,
   input  wire [`LSU_SHAMT_W-1:0]      i_shamt,
   output logic                        o_op_b
);
   import mem_bus_pkg::*;

   mem_word_t sreg;

   always_ff @(posedge i_clk) begin
      if (i_capture)
         sreg <= i_shift_op ? {{(`LSU_XLEN-`LSU_SHAMT_W){1'b0}}, i_shamt} : i_rs2;
      else if (i_en)
         sreg <= sreg >> 1; // next bit to the bottom.
   end

   assign o_op_b = sreg[0]; // lsb first.

endmodule

`default_nettype wire

/* rtl/data_bufreg.sv */
`default_nettype none

`include "lsu_config.svh"

module data_bufreg (
   input  wire                         i_clk,
   input  wire                         i_en,
   input  wire                         i_init,
   input  wire                         i_cnt_done,
   input  wire [1:0]                   i_lsb,
   input  wire [1:0]                   i_bytecnt,
   input  wire                         i_shift_op,
   input  wire                         i_op_b,
   input  wire                         i_load,
   input  wire mem_bus_pkg::mem_word_t i_dat,
   output logic                        o_sh_done,
   output logic                        o_q,
   output mem_bus_pkg::mem_word_t      o_dat
);
   import serial_op_pkg::*;
   import mem_bus_pkg::*;

   localparam int UPPER_W = `LSU_XLEN - `LSU_SHAMT_W - 1;

   bufreg_word_u          dat;
   logic                  byte_valid;
   logic                  shift_en;
   logic                  cnt_en;
   logic                  fill;
   logic [`LSU_SHAMT_W:0] cnt_nxt;

   // shift only while the current byte still lands inside the word
   assign byte_valid = ({1'b0, i_lsb} + {1'b0, i_bytecnt}) < 3'd4;
   assign shift_en   = i_en & (i_shift_op ? i_init : byte_valid);
   assign cnt_en     = i_shift_op & !i_init; // counter mode after shift init.
   assign fill       = i_init & i_op_b;      // zeros behind load data.

   assign cnt_nxt = cnt_en ? dat.f.cnt - 1'b1 :                     // count down.
                    {dat.f.upper[0] & !(i_shift_op & i_cnt_done),  // clear wrap bit.
                     dat.f.cnt[`LSU_SHAMT_W:1]};

   assign o_sh_done = cnt_nxt[`LSU_SHAMT_W];    // counter wrapped below zero.
   assign o_q       = dat.word[{i_lsb, 3'b000}]; // first bit of the addressed lane.
   assign o_dat     = dat.word;

   always_ff @(posedge i_clk) begin
      if (i_load)
         dat.word <= i_dat; // read data from the bus.
      else if (cnt_en)
         dat.f.cnt <= cnt_nxt;
      else if (shift_en)
         dat.word <= {fill, dat.f.upper[UPPER_W-1:1], cnt_nxt};
   end

endmodule

`default_nettype wire

/* rtl/shift_accumulator.sv */
`default_nettype none

module shift_accumulator (
   input  wire                         i_clk,
   input  wire                         i_capture,
   input  wire mem_bus_pkg::mem_word_t i_rs1,
   input  wire                         i_step,
   input  wire                         i_left,
   output mem_bus_pkg::mem_word_t      o_result
);
   import mem_bus_pkg::*;

   mem_word_t acc;

   always_ff @(posedge i_clk) begin
      if (i_capture)
         acc <= i_rs1;
      else if (i_step)
         acc <= i_left ? (acc << 1) : (acc >> 1); // logical, zero fill.
   end

   assign o_result = acc;

endmodule

`default_nettype wire

/* rtl/mem_bus_master.sv */
`default_nettype none

module mem_bus_master (
   input  wire                           i_clk,
   input  wire                           i_rst_n,
   input  wire                           i_capture,
   input  wire                           i_start,
   input  wire                           i_we,
   input  wire mem_bus_pkg::mem_addr_t   i_addr,
   input  wire serial_op_pkg::mem_size_e i_size,
   input  wire mem_bus_pkg::mem_word_t   i_wdata,
   input  wire                           i_mem_ready,
   output logic                          o_mem_valid,
   output logic                          o_mem_we,
   output mem_bus_pkg::mem_addr_t        o_mem_addr,
   output mem_bus_pkg::mem_word_t        o_mem_wdata,
   output mem_bus_pkg::mem_be_t          o_mem_be,
   output logic                          o_load,
   output logic                          o_done
);
   import serial_op_pkg::*;
   import mem_bus_pkg::*;

   mem_be_t be_base;

   always_comb begin
      case (i_size)
         BYTE:    be_base = mem_be_t'(1);
         HALF:    be_base = mem_be_t'(3);
         default: be_base = '1;
      endcase
   end

   // request fields are taken with the command and held to the end
   always_ff @(posedge i_clk) begin
      if (i_capture) begin
         o_mem_we   <= i_we;
         o_mem_addr <= i_addr & ~mem_addr_t'(3); // word aligned.
         o_mem_be   <= be_base << i_addr[1:0];   // lanes above the word drop out.
      end
   end

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n)
         o_mem_valid <= 1'b0;
      else if (i_start)
         o_mem_valid <= 1'b1;
      else if (o_done)
         o_mem_valid <= 1'b0;
   end

   assign o_mem_wdata = i_wdata;                 // buffer is frozen while in BUS.
   assign o_done      = o_mem_valid & i_mem_ready;
   assign o_load      = o_done & !o_mem_we;      // read data valid on this edge.

endmodule

`default_nettype wire

/* rtl/result_collector.sv */
`default_nettype none

module result_collector (
   input  wire                           i_clk,
   input  wire                           i_rst_n,
   input  wire                           i_capture,
   input  wire                           i_bit_en,
   input  wire                           i_q,
   input  wire serial_op_pkg::mem_size_e i_size,
   input  wire                           i_signed,
   input  wire                           i_capture_word,
   input  wire mem_bus_pkg::mem_word_t   i_word,
   input  wire                           i_set_valid,
   input  wire                           i_rsp_ready,
   output logic                          o_rsp_valid,
   output mem_bus_pkg::mem_word_t        o_rsp_data
);
   import serial_op_pkg::*;
   import mem_bus_pkg::*;

   localparam int W = $bits(mem_word_t);

   mem_size_e size_q;
   logic      signed_q;
   logic      sign;
   mem_word_t shifted;
   mem_word_t extended;

   assign shifted = {i_q, o_rsp_data[W-1:1]}; // bits enter from the top.

   always_comb begin
      sign     = 1'b0;
      extended = shifted;
      case (size_q)
         BYTE: begin
            sign              = signed_q & shifted[7];
            extended[W-1:8]   = {(W-8){sign}};
         end
         HALF: begin
            sign              = signed_q & shifted[15];
            extended[W-1:16]  = {(W-16){sign}};
         end
         default: extended = shifted; // full word, nothing to extend.
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (i_capture) begin
         size_q   <= i_size;
         signed_q <= i_signed;
      end
      if (i_capture_word)
         o_rsp_data <= i_word;                          // shift result.
      else if (i_bit_en)
         o_rsp_data <= i_set_valid ? extended : shifted; // last load bit extends.
      else if (i_set_valid)
         o_rsp_data <= '0;                              // store answers zero.
   end

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n)
         o_rsp_valid <= 1'b0;
      else if (i_set_valid)
         o_rsp_valid <= 1'b1;
      else if (i_rsp_ready)
         o_rsp_valid <= 1'b0;
   end

endmodule

`default_nettype wire

/* rtl/serial_lsu_top.sv */
`default_nettype none

`include "lsu_config.svh"

module serial_lsu_top (
   input  wire                           i_clk,
   input  wire                           i_rst_n,
   input  wire                           i_cmd_valid,
   output wire                           o_cmd_ready,
   input  wire serial_op_pkg::lsu_op_e   i_cmd_op,
   input  wire serial_op_pkg::mem_size_e i_cmd_size,
   input  wire                           i_cmd_signed,
   input  wire mem_bus_pkg::mem_addr_t   i_cmd_addr,
   input  wire mem_bus_pkg::mem_word_t   i_cmd_rs1,
   input  wire mem_bus_pkg::mem_word_t   i_cmd_rs2,
   input  wire [`LSU_SHAMT_W-1:0]        i_cmd_shamt,
   output wire                           o_rsp_valid,
   input  wire                           i_rsp_ready,
   output wire mem_bus_pkg::mem_word_t   o_rsp_data,
   output wire                           o_mem_valid,
   input  wire                           i_mem_ready,
   output wire                           o_mem_we,
   output wire mem_bus_pkg::mem_addr_t   o_mem_addr,
   output wire mem_bus_pkg::mem_word_t   o_mem_wdata,
   output wire mem_bus_pkg::mem_be_t     o_mem_be,
   input  wire mem_bus_pkg::mem_word_t   i_mem_rdata
);
   import serial_op_pkg::*;
   import mem_bus_pkg::*;

   seq_phase_e phase;
   logic       en, init, cnt_done, shift_op, shift_left;
   logic [1:0] bytecnt, lsb;
   logic       sh_done, op_b, q, mem_load, mem_done;
   mem_word_t  buf_dat, acc_result;
   logic       accept, in_exec, mem_start, acc_step, rsp_set, shift_end;

   assign accept    = i_cmd_valid & o_cmd_ready;
   assign in_exec   = (phase == EXEC);
   assign mem_start = (accept & (i_cmd_op == LOAD)) |  // loads start on accept.
                      (init & cnt_done & !shift_op);  // stores after alignment.
   assign shift_end = in_exec & shift_op & sh_done;
   assign acc_step  = in_exec & shift_op & !sh_done; // exactly n steps.
   assign rsp_set   = ((phase == BUS) & mem_done & o_mem_we) |
                      (in_exec & (shift_op ? sh_done : cnt_done));

   serial_sequencer u_seq (
      .i_clk, .i_rst_n, .i_cmd_valid, .i_cmd_op,
      .i_cmd_lsb   (i_cmd_addr[1:0]),
      .i_mem_done  (mem_done),
      .i_sh_done   (sh_done),
      .i_rsp_ready,
      .o_cmd_ready,
      .o_phase     (phase),
      .o_en        (en),
      .o_init      (init),
      .o_cnt_done  (cnt_done),
      .o_bytecnt   (bytecnt),
      .o_lsb       (lsb),
      .o_shift_op  (shift_op),
      .o_shift_left(shift_left)
   );

   operand_serializer u_opb (
      .i_clk,
      .i_capture (accept),
      .i_en      (en),
      .i_shift_op((i_cmd_op == SLL) | (i_cmd_op == SRL)), // command op, not the held one.
      .i_rs2     (i_cmd_rs2),
      .i_shamt   (i_cmd_shamt),
      .o_op_b    (op_b)
   );

   data_bufreg u_buf (
      .i_clk,
      .i_en      (en),
      .i_init    (init),
      .i_cnt_done(cnt_done),
      .i_lsb     (lsb),
      .i_bytecnt (bytecnt),
      .i_shift_op(shift_op),
      .i_op_b    (op_b),
      .i_load    (mem_load),
      .i_dat     (i_mem_rdata),
      .o_sh_done (sh_done),
      .o_q       (q),
      .o_dat     (buf_dat)
   );

   shift_accumulator u_acc (
      .i_clk,
      .i_capture(accept),
      .i_rs1    (i_cmd_rs1),
      .i_step   (acc_step),
      .i_left   (shift_left),
      .o_result (acc_result)
   );

   mem_bus_master u_bus (
      .i_clk, .i_rst_n,
      .i_capture  (accept),
      .i_start    (mem_start),
      .i_we       (i_cmd_op == STORE),
      .i_addr     (i_cmd_addr),
      .i_size     (i_cmd_size),
      .i_wdata    (buf_dat),
      .i_mem_ready,
      .o_mem_valid, .o_mem_we, .o_mem_addr, .o_mem_wdata, .o_mem_be,
      .o_load     (mem_load),
      .o_done     (mem_done)
   );

   result_collector u_rsp (
      .i_clk, .i_rst_n,
      .i_capture     (accept),
      .i_bit_en      (en & !init), // load extraction bits only.
      .i_q           (q),
      .i_size        (i_cmd_size),
      .i_signed      (i_cmd_signed),
      .i_capture_word(shift_end),
      .i_word        (acc_result),
      .i_set_valid   (rsp_set),
      .i_rsp_ready,
      .o_rsp_valid, .o_rsp_data
   );

endmodule

`default_nettype wire

/* verif/tb_mem_model.sv */
`default_nettype none

module tb_mem_model (
   input  wire                         i_clk,
   input  wire                         i_rst_n,
   input  wire                         i_valid,
   output logic                        o_ready,
   input  wire                         i_we,
   input  wire mem_bus_pkg::mem_addr_t i_addr,
   input  wire mem_bus_pkg::mem_word_t i_wdata,
   input  wire mem_bus_pkg::mem_be_t   i_be,
   output mem_bus_pkg::mem_word_t      o_rdata
);
   timeunit 1ns;
   timeprecision 100ps;
   import mem_bus_pkg::*;

   localparam int          DEPTH = 16;
   localparam logic [31:0] TAPS  = 32'h8020_0003; // x^32 + x^22 + x^2 + x + 1.

   mem_word_t   mem [DEPTH];
   logic [31:0] lfsr_state = 32'h1710;
   logic [1:0]  stall;
   logic        xfer;

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ TAPS) : (s >> 1);
   endfunction

   // two lfsr bits give a stall of 0 to 3 cycles
   function automatic logic [1:0] next_stall();
      logic [1:0] v;
      int         k;
      v = 2'd0;
      for (k = 0; k < 2; k++) begin
         lfsr_state = lfsr_step(lfsr_state);
         v          = {v[0], lfsr_state[0]};
      end
      return v;
   endfunction

   function automatic mem_word_t fill_word(input mem_addr_t a);
      return (a * 32'h9e37_79b9) ^ {a[15:0], ~a[15:0]}; // every address bit counts.
   endfunction

   initial begin
      int i;
      int b;
      for (i = 0; i < DEPTH; i++)
         mem[i] = fill_word(mem_addr_t'(i * 4));
      o_ready = 1'b0;
      o_rdata = '0;
      stall   = next_stall();
      forever begin
         @(posedge i_clk);
         xfer = o_ready & i_valid; // transfer completes on this edge.
         if (xfer & i_we) begin
            for (b = 0; b < 4; b++)
               if (i_be[b])
                  mem[i_addr[5:2]][8*b +: 8] = i_wdata[8*b +: 8];
         end
         #1;
         if (!i_rst_n) begin
            o_ready = 1'b0;
         end else if (xfer) begin
            o_ready = 1'b0;
            stall   = next_stall(); // new stall for the next request.
         end else if (i_valid & !o_ready) begin
            if (stall == 2'd0) begin
               o_ready = 1'b1;
               o_rdata = mem[i_addr[5:2]]; // 16 words, upper address bits alias.
            end else begin
               stall = stall - 2'd1;
            end
         end
      end
   end

endmodule

`default_nettype wire

/* verif/tb_serial_lsu.sv */
`default_nettype none

`include "lsu_config.svh"

module tb_serial_lsu;
   timeunit 1ns;
   timeprecision 100ps;
   import serial_op_pkg::*;
   import mem_bus_pkg::*;

   localparam logic [31:0] TAPS  = 32'h8020_0003;
   localparam int          LIMIT = 200; // cycles allowed for one wait.

   logic clk, rst_n, cmd_valid, cmd_signed, rsp_ready;
   wire  cmd_ready, rsp_valid, mem_valid, mem_ready, mem_we;
   lsu_op_e                 cmd_op;
   mem_size_e               cmd_size;
   mem_addr_t               cmd_addr;
   mem_word_t               cmd_rs1, cmd_rs2;
   logic [`LSU_SHAMT_W-1:0] cmd_shamt;
   wire mem_word_t          rsp_data, mem_wdata, mem_rdata;
   wire mem_addr_t          mem_addr;
   wire mem_be_t            mem_be;

   logic [31:0] lfsr_state = 32'h1710;
   int          errors = 0, checks = 0, cycle = 0, accept_cycle = 0;
   logic        hung = 1'b0, rsp_seen = 1'b0;
   mem_word_t   exp_data_q[$], exp_word_q[$];
   int          exp_lat_q[$], exp_idx_q[$];
   logic        bus_wait = 1'b0, rsp_hold = 1'b0, bus_we;
   mem_addr_t   bus_addr;
   mem_word_t   bus_wdata, rsp_prev;
   mem_be_t     bus_be;

   serial_lsu_top dut (
      .i_clk(clk), .i_rst_n(rst_n), .i_cmd_valid(cmd_valid), .o_cmd_ready(cmd_ready),
      .i_cmd_op(cmd_op), .i_cmd_size(cmd_size), .i_cmd_signed(cmd_signed),
      .i_cmd_addr(cmd_addr), .i_cmd_rs1(cmd_rs1), .i_cmd_rs2(cmd_rs2), .i_cmd_shamt(cmd_shamt),
      .o_rsp_valid(rsp_valid), .i_rsp_ready(rsp_ready), .o_rsp_data(rsp_data),
      .o_mem_valid(mem_valid), .i_mem_ready(mem_ready), .o_mem_we(mem_we),
      .o_mem_addr(mem_addr), .o_mem_wdata(mem_wdata), .o_mem_be(mem_be),
      .i_mem_rdata(mem_rdata)
   );

   tb_mem_model u_mem (
      .i_clk(clk), .i_rst_n(rst_n), .i_valid(mem_valid), .o_ready(mem_ready),
      .i_we(mem_we), .i_addr(mem_addr), .i_wdata(mem_wdata), .i_be(mem_be),
      .o_rdata(mem_rdata)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk; // 10 ns period.
   end

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ TAPS) : (s >> 1);
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      int          k;
      v = '0;
      for (k = 0; k < n; k++) begin
         lfsr_state = lfsr_step(lfsr_state); // one step per bit taken.
         v          = {v[30:0], lfsr_state[0]};
      end
      return v;
   endfunction

   // new memory word: lanes 1, 3 or 15 shifted up by lsb take rs2 moved up by 8*lsb
   function automatic mem_word_t merge_store(input mem_word_t old, input mem_word_t rs2,
                                             input mem_size_e size, input logic [1:0] lsb);
      mem_word_t  aligned;
      logic [7:0] lanes;
      int         b;
      aligned = rs2 << (8 * lsb);
      lanes   = ((size == BYTE) ? 8'h01 : (size == HALF) ? 8'h03 : 8'h0f) << lsb;
      for (b = 0; b < 4; b++)
         if (lanes[b])
            old[8*b +: 8] = aligned[8*b +: 8];
      return old;
   endfunction

   function automatic mem_word_t expect_rsp(input lsu_op_e op, input mem_size_e size,
                                            input logic sgn, input logic [1:0] lsb,
                                            input mem_word_t rs1, input logic [4:0] shamt,
                                            input mem_word_t word);
      mem_word_t v;
      case (op)
         STORE:   v = '0;
         SLL:     v = rs1 << shamt;
         SRL:     v = rs1 >> shamt;
         default: begin
            v = word >> (8 * lsb); // addressed byte to the bottom.
            if (size == BYTE)
               v = {{24{sgn & v[7]}}, v[7:0]};
            else if (size == HALF)
               v = {{16{sgn & v[15]}}, v[15:0]};
         end
      endcase
      return v;
   endfunction

   task automatic run_cmd(input lsu_op_e op, input mem_size_e size, input logic sgn,
                          input mem_addr_t addr, input mem_word_t rs1, input mem_word_t rs2,
                          input logic [4:0] shamt);
      int        idx, lat, n, hold;
      logic      taken, seen;
      mem_word_t word;
      if (hung)
         return;
      idx  = addr[5:2];
      word = u_mem.mem[idx]; // memory is quiet between commands.
      lat  = (op == SLL || op == SRL) ? 33 + int'(shamt) : -1;
      exp_data_q.push_back(expect_rsp(op, size, sgn, addr[1:0], rs1, shamt, word));
      exp_lat_q.push_back(lat);
      exp_idx_q.push_back((op == STORE) ? idx : -1);
      exp_word_q.push_back(merge_store(word, rs2, size, addr[1:0]));
      cmd_valid  = 1'b1;
      cmd_op     = op;
      cmd_size   = size;
      cmd_signed = sgn;
      cmd_addr   = addr;
      cmd_rs1    = rs1;
      cmd_rs2    = rs2;
      cmd_shamt  = shamt;
      n = 0;
      do begin
         @(posedge clk);
         taken = cmd_ready;
         #1;
         n++;
      end while (!taken && n < LIMIT);
      cmd_valid = 1'b0;
      if (!taken) begin
         $display("timeout: command was never accepted");
         hung = 1'b1;
         return;
      end
      hold = rand_bits(2); // response back-pressure, 0 to 3 cycles.
      n    = 0;
      do begin
         @(posedge clk);
         seen = rsp_valid;
         #1;
         n++;
      end while (!seen && n < LIMIT);
      if (!seen) begin
         $display("timeout: no response after the command was accepted");
         hung = 1'b1;
         return;
      end
      repeat (hold) begin
         @(posedge clk);
         #1;
      end
      rsp_ready = 1'b1;
      @(posedge clk); // handshake edge.
      #1;
      rsp_ready = 1'b0;
   endtask

   // response compare, with the shift latency taken from accept to valid
   always @(posedge clk) begin
      cycle = cycle + 1;
      if (cmd_valid && cmd_ready)
         accept_cycle = cycle;
      if (rsp_valid && !rsp_seen) begin
         rsp_seen = 1'b1;
         if (exp_lat_q.size() > 0 && exp_lat_q[0] >= 0) begin
            checks++;
            if (cycle - 1 - accept_cycle != exp_lat_q[0]) begin
               errors++;
               $display("FAILED o_rsp_valid latency got %h expected %h",
                        cycle - 1 - accept_cycle, exp_lat_q[0]);
            end
         end
      end
      if (rsp_valid && rsp_ready) begin
         rsp_seen = 1'b0;
         if (exp_data_q.size() == 0) begin
            errors++;
            $display("a response came with no command outstanding");
         end else begin
            checks++;
            if (rsp_data !== exp_data_q[0]) begin
               errors++;
               $display("FAILED o_rsp_data got %h expected %h", rsp_data, exp_data_q[0]);
            end
            if (exp_idx_q[0] >= 0) begin
               checks++;
               if (u_mem.mem[exp_idx_q[0]] !== exp_word_q[0]) begin
                  errors++;
                  $display("FAILED mem[%0d] got %h expected %h", exp_idx_q[0],
                           u_mem.mem[exp_idx_q[0]], exp_word_q[0]);
               end
            end
            void'(exp_data_q.pop_front());
            void'(exp_lat_q.pop_front());
            void'(exp_idx_q.pop_front());
            void'(exp_word_q.pop_front());
         end
      end
   end

   // bus and response hold rules, checked cycle by cycle
   always @(posedge clk) begin
      if (rst_n) begin
         if (bus_wait && (!mem_valid || mem_we !== bus_we || mem_addr !== bus_addr ||
                          mem_wdata !== bus_wdata || mem_be !== bus_be)) begin
            errors++;
            $display("FAILED o_mem_* changed while stalled, addr %h was %h",
                     mem_addr, bus_addr);
         end
         if (mem_valid && mem_addr[1:0] != 2'b00) begin
            errors++;
            $display("FAILED o_mem_addr got %h expected %h", mem_addr, mem_addr & ~32'h3);
         end
         if (rsp_hold && (!rsp_valid || rsp_data !== rsp_prev)) begin
            errors++;
            $display("FAILED o_rsp_data got %h expected %h while held", rsp_data, rsp_prev);
         end
         if (rsp_valid && cmd_ready) begin
            errors++;
            $display("o_cmd_ready was high while a response was pending");
         end
      end
      bus_wait  = mem_valid && !mem_ready;
      bus_we    = mem_we;
      bus_addr  = mem_addr;
      bus_wdata = mem_wdata;
      bus_be    = mem_be;
      rsp_hold  = rsp_valid && !rsp_ready;
      rsp_prev  = rsp_data;
   end

   initial begin
      int         s, l, g, i;
      mem_addr_t  addr;
      mem_word_t  rs1, rs2;
      logic [4:0] amt;
      rst_n      = 1'b0;
      cmd_valid  = 1'b0;
      cmd_op     = LOAD;
      cmd_size   = BYTE;
      cmd_signed = 1'b0;
      cmd_addr   = '0;
      cmd_rs1    = '0;
      cmd_rs2    = '0;
      cmd_shamt  = '0;
      rsp_ready  = 1'b0;
      repeat (10) @(posedge clk);
      #1;
      rst_n = 1'b1;
      checks++;
      if (!cmd_ready || rsp_valid || mem_valid) begin
         errors++;
         $display("wrong handshake levels after reset");
      end
      for (s = 0; s < 3; s++) begin
         for (l = 0; l < 4; l++) begin
            addr = (rand_bits(30) << 2) | mem_addr_t'(l);
            rs2  = rand_bits(32);
            run_cmd(STORE, mem_size_e'(s), 1'b0, addr, '0, rs2, 5'd0);
         end
      end
      for (s = 0; s < 3; s++) begin
         for (g = 0; g < 2; g++) begin
            for (l = 0; l < 4; l++) begin
               addr = (rand_bits(30) << 2) | mem_addr_t'(l);
               run_cmd(LOAD, mem_size_e'(s), g[0], addr, '0, '0, 5'd0);
            end
         end
      end
      for (i = 0; i < 24; i++) begin
         rs1 = rand_bits(32);
         amt = (i == 0) ? 5'd0 : (i == 1) ? 5'd31 : rand_bits(5); // both ends first.
         run_cmd(rand_bits(1) ? SLL : SRL, WORD, 1'b0, '0, rs1, '0, amt);
      end
      $display("checks: %0d  errors: %0d  timeout: %0d", checks, errors, hung);
      if (errors == 0 && !hung && exp_data_q.size() == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

endmodule

`default_nettype wire

/* sim.f */
+incdir+rtl
rtl/serial_op_pkg.sv
rtl/mem_bus_pkg.sv
rtl/serial_sequencer.sv
rtl/operand_serializer.sv
rtl/data_bufreg.sv
rtl/shift_accumulator.sv
rtl/mem_bus_master.sv
rtl/result_collector.sv
rtl/serial_lsu_top.sv
verif/tb_mem_model.sv
verif/tb_serial_lsu.sv

/* Bender.yml */
package:
  name: serial_lsu

export_include_dirs:
  - rtl

sources:
  - rtl/serial_op_pkg.sv
  - rtl/mem_bus_pkg.sv
  - rtl/serial_sequencer.sv
  - rtl/operand_serializer.sv
  - rtl/data_bufreg.sv
  - rtl/shift_accumulator.sv
  - rtl/mem_bus_master.sv
  - rtl/result_collector.sv
  - rtl/serial_lsu_top.sv
  - target: test
    files:
      - verif/tb_mem_model.sv
      - verif/tb_serial_lsu.sv
